/* dv/tb_cl_rdata_mult.sv */
`timescale 1ns/100ps
// Testbench for the read-data product path
// Clock, reset, beat stimulus, expected-beat queue, assertions, timeout
module tb_cl_rdata_mult;

   import rdata_mult_pkg::*;

   localparam int PROD_BEATS  = 64;
   localparam int BP_BEATS    = 128;
   localparam int ALL_BEATS   = PROD_BEATS + 1 + BP_BEATS;
   localparam int FIXED_WAITS = 120;
   localparam int CYCLE_LIMIT = 2 * (ALL_BEATS + FIXED_WAITS) + 200;

   typedef struct packed {
      logic [BEAT_W-1:0] data;
      logic [ID_W-1:0]   id;
      logic              last;
   } exp_beat_t;

   logic              clk;
   logic              sync_rst_n;
   logic              rd_in_valid;
   logic              rd_in_ready;
   logic [BEAT_W-1:0] rd_in_data;
   logic [ID_W-1:0]   rd_in_id;
   logic              rd_in_last;
   logic              rd_out_valid;
   logic              rd_out_ready;
   logic [BEAT_W-1:0] rd_out_data;
   logic [ID_W-1:0]   rd_out_id;
   logic              rd_out_last;
   logic [31:0]       ctl0;
   logic [31:0]       status0;
   logic [31:0]       status1;
   logic [31:0]       id0;
   logic [31:0]       id1;
   logic              flr_assert;
   logic              flr_done;

   integer            seed;
   int                errors;
   int                err_mark;
   int                tests;
   int                cycle_cnt;
   string             test_name;
   exp_beat_t         exp_q[$];
   exp_beat_t         new_beat;
   exp_beat_t         exp_front;
   logic              exp_avail;
   logic [BEAT_W-1:0] last_prod;
   int                accepted_total;
   int                delivered_total;
   logic              chk_reset;
   logic              chk_dbg;
   logic              chk_cnt;
   logic              chk_idle;
   logic              lat_arm;
   logic [31:0]       exp_id0;
   logic [31:0]       exp_id1;
   logic              in_fire;
   logic              out_fire;

   cl_rdata_mult i_cl_rdata_mult (.*);

   assign in_fire  = rd_in_valid && rd_in_ready;
   assign out_fire = rd_out_valid && rd_out_ready;

   initial
   begin
      clk = 1'b0;
   end

   always #4 clk = ~clk;

   // Each lane product is hi * lo of the same 64-bit lane, unsigned
   function automatic logic [BEAT_W-1:0] lane_products(input logic [BEAT_W-1:0] data);
      logic [BEAT_W-1:0] res;
      logic [63:0]       hi;
      logic [63:0]       lo;
      int                i;
      for (i = 0; i < LANES; i++)
      begin
         hi = {32'h0, data[64*i+32 +: 32]};
         lo = {32'h0, data[64*i +: 32]};
         res[64*i +: 64] = hi * lo;
      end
      return res;
   endfunction

   // ------------------------------
   // Expected-beat queue
   // ------------------------------
   always @(posedge clk)
   begin
      if (sync_rst_n)
      begin
         if (out_fire && exp_q.size() > 0)
         begin
            last_prod <= exp_q[0].data;
            void'(exp_q.pop_front());
         end
         if (out_fire)
         begin
            delivered_total <= delivered_total + 1;
         end
         if (in_fire)
         begin
            new_beat.data = lane_products(rd_in_data);
            new_beat.id   = rd_in_id;
            new_beat.last = rd_in_last;
            exp_q.push_back(new_beat);
            accepted_total <= accepted_total + 1;
         end
      end
      exp_avail <= (exp_q.size() > 0);
      if (exp_q.size() > 0)
      begin
         exp_front <= exp_q[0];
      end
   end

   task automatic log_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // ------------------------------
   // Checks
   // ------------------------------
   out_expected_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      out_fire |-> exp_avail)
      else log_failure($sformatf("%s: output beat delivered with none expected", test_name));

   out_data_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      out_fire && exp_avail |-> rd_out_data == exp_front.data)
      else log_failure($sformatf("error %s: rd_out_data expected %h actual %h",
         test_name, $sampled(exp_front.data), $sampled(rd_out_data)));

   out_id_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      out_fire && exp_avail |-> rd_out_id == exp_front.id && rd_out_last == exp_front.last)
      else log_failure($sformatf("error %s: id/last expected %h/%b actual %h/%b", test_name,
         $sampled(exp_front.id), $sampled(exp_front.last), $sampled(rd_out_id),
         $sampled(rd_out_last)));

   out_hold_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      rd_out_valid && !rd_out_ready |=> rd_out_valid && $stable(rd_out_data)
         && $stable(rd_out_id) && $stable(rd_out_last))
      else log_failure($sformatf("%s: stalled output beat changed", test_name));

   idle_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      chk_idle |-> !rd_out_valid)
      else log_failure($sformatf("%s: extra output beat after the stream", test_name));

   // Single beat into an empty path shows up after four edges
   latency_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      lat_arm && in_fire |-> ##1 !rd_out_valid ##1 !rd_out_valid ##1 !rd_out_valid
         ##1 !rd_out_valid ##1 rd_out_valid)
      else log_failure($sformatf("%s: rd_out_valid not seen 4 edges after input",
         test_name));

   reset_state_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      chk_reset |-> !rd_out_valid && !flr_done && rd_in_ready)
      else log_failure($sformatf("%s: outputs not in reset state", test_name));

   status_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      status0 == {STATUS_TAG, 16'(delivered_total)} && status1 == DEF_VERSION)
      else log_failure($sformatf("error %s: status0/1 expected %h/%h actual %h/%h",
         test_name, {STATUS_TAG, 16'($sampled(delivered_total))}, DEF_VERSION,
         $sampled(status0), $sampled(status1)));

   count_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      chk_cnt |-> status0[15:0] == 16'(ALL_BEATS))
      else log_failure($sformatf("error %s: beat count expected %h actual %h",
         test_name, 16'(ALL_BEATS), $sampled(status0[15:0])));

   id0_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      chk_dbg |-> id0 == exp_id0)
      else log_failure($sformatf("error %s: id0 expected %h actual %h",
         test_name, $sampled(exp_id0), $sampled(id0)));

   id1_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      chk_dbg |-> id1 == exp_id1)
      else log_failure($sformatf("error %s: id1 expected %h actual %h",
         test_name, $sampled(exp_id1), $sampled(id1)));

   flr_rise_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      $rose(flr_assert) |-> !flr_done ##1 !flr_done ##1 flr_done ##1 !flr_done ##1 flr_done)
      else log_failure($sformatf("%s: flr_done wrong after flr_assert rose", test_name));

   flr_alt_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      flr_assert && $past(flr_assert) && $past(flr_assert, 2) |-> flr_done != $past(flr_done))
      else log_failure($sformatf("%s: flr_done did not alternate", test_name));

   flr_fall_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      $fell(flr_assert) |-> ##2 !flr_done ##1 !flr_done)
      else log_failure($sformatf("%s: flr_done high after flr_assert fell", test_name));

   // ------------------------------
   // Stimulus helpers
   // ------------------------------
   task automatic make_beat(input int idx, output logic [BEAT_W-1:0] data,
                            output logic [ID_W-1:0] id);
      int w;
      for (w = 0; w < BEAT_W / 32; w++)
      begin
         data[32*w +: 32] = $random(seed);
      end
      id = ID_W'($random(seed));
      // Corner operands on the first beats of a stream
      case (idx)
         0: data = '1;
         1: data = '0;
         default: ;
      endcase
      for (w = 0; w < LANES; w++)
      begin
         if (idx == 2)
         begin
            data[64*w+32 +: 32] = '1;
         end
         if (idx == 3)
         begin
            data[64*w +: 32] = '1;
         end
      end
   endtask

   task automatic send_beats(input int n, input bit bp);
      int                sent;
      logic [BEAT_W-1:0] data;
      logic [ID_W-1:0]   id;
      sent = 0;
      @(posedge clk);
      make_beat(0, data, id);
      rd_in_valid <= 1'b1;
      rd_in_data  <= data;
      rd_in_id    <= id;
      rd_in_last  <= (n == 1);
      while (sent < n)
      begin
         @(posedge clk);
         if (bp)
         begin
            rd_out_ready <= 1'($random(seed));
         end
         // Valid is held, so ready at this edge means a transfer
         if (rd_in_ready)
         begin
            sent++;
            if (sent < n)
            begin
               make_beat(sent, data, id);
               rd_in_data <= data;
               rd_in_id   <= id;
               rd_in_last <= (sent % 8 == 7) || (sent == n - 1);
            end
            else
            begin
               rd_in_valid <= 1'b0;
            end
         end
      end
   endtask

   task automatic drain(input bit bp);
      // Accept count of the final beat settles on this edge
      @(posedge clk);
      while (delivered_total < accepted_total)
      begin
         @(posedge clk);
         if (bp)
         begin
            rd_out_ready <= 1'($random(seed));
         end
      end
      @(posedge clk);
      rd_out_ready <= 1'b1;
      chk_idle     <= 1'b1;
      repeat (3) @(posedge clk);
      chk_idle <= 1'b0;
   endtask

   task automatic set_ctl(input logic [31:0] word, input logic [31:0] e0,
                          input logic [31:0] e1);
      @(posedge clk);
      ctl0    <= word;
      chk_dbg <= 1'b0;
      exp_id0 <= e0;
      exp_id1 <= e1;
      repeat (2) @(posedge clk);
      chk_dbg <= 1'b1;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_mark  = errors;
   endtask

   task automatic end_test();
      @(posedge clk);
      tests++;
      $display("test %s finished, %0d errors", test_name, errors - err_mark);
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial
   begin
      logic [31:0] ctl_word;
      int          k;
      seed            = 32'hc5ff_cfb2;
      errors          = 0;
      err_mark        = 0;
      tests           = 0;
      cycle_cnt       = 0;
      test_name       = "reset";
      accepted_total  = 0;
      delivered_total = 0;
      exp_avail       = 1'b0;
      last_prod       = '0;
      sync_rst_n      = 1'b0;
      rd_in_valid     = 1'b0;
      rd_in_data      = '0;
      rd_in_id        = '0;
      rd_in_last      = 1'b0;
      rd_out_ready    = 1'b1;
      ctl0            = '0;
      flr_assert      = 1'b0;
      chk_reset       = 1'b0;
      chk_dbg         = 1'b0;
      chk_cnt         = 1'b0;
      chk_idle        = 1'b0;
      lat_arm         = 1'b0;
      exp_id0         = DEF_ID0;
      exp_id1         = DEF_ID1;
      repeat (5) @(posedge clk);
      sync_rst_n <= 1'b1;

      start_test("reset");
      @(posedge clk);
      chk_reset <= 1'b1;
      chk_dbg   <= 1'b1;
      @(posedge clk);
      chk_reset <= 1'b0;
      chk_dbg   <= 1'b0;
      end_test();

      start_test("products");
      send_beats(PROD_BEATS, 1'b0);
      drain(1'b0);
      end_test();

      start_test("latency");
      lat_arm <= 1'b1;
      send_beats(1, 1'b0);
      drain(1'b0);
      lat_arm <= 1'b0;
      end_test();

      start_test("backpressure");
      send_beats(BP_BEATS, 1'b1);
      drain(1'b1);
      end_test();

      start_test("debug");
      @(posedge clk);
      chk_cnt <= 1'b1;
      @(posedge clk);
      chk_cnt <= 1'b0;
      for (k = 0; k < LANES; k++)
      begin
         ctl_word = '0;
         ctl_word[CTL_DBG_EN_BIT] = 1'b1;
         ctl_word[CTL_LANE_SEL_LSB +: LANE_SEL_W] = LANE_SEL_W'(k);
         set_ctl(ctl_word, last_prod[64*k +: 32], last_prod[64*k+32 +: 32]);
      end
      set_ctl(32'h0, DEF_ID0, DEF_ID1);
      @(posedge clk);
      chk_dbg <= 1'b0;
      end_test();

      start_test("flr");
      @(posedge clk);
      flr_assert <= 1'b1;
      repeat (10) @(posedge clk);
      flr_assert <= 1'b0;
      repeat (5) @(posedge clk);
      end_test();

      $display("%0d tests run, %0d checks failed", tests, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   // Run limit from the planned beats and fixed waits
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("run stopped in test %s after %0d cycles", test_name, cycle_cnt);
         $display("Test failed");
         $finish;
      end
   end

endmodule

/* hw/beat_if.sv */
`timescale 1ns/100ps
// Valid/ready beat stream carrying one payload per transfer
// Source, sink and monitor views of the stream
interface beat_if #(
   parameter type payload_t = logic
) ();

   logic     valid;
   logic     ready;
   payload_t payload;

   // Producer of the stream
   modport source (
      output valid,
      output payload,
      input  ready
   );

   // Consumer of the stream
   modport sink (
      input  valid,
      input  payload,
      output ready
   );

   // Passive observer, counts and captures transfers
   modport monitor (
      input valid,
      input ready,
      input payload
   );

endinterface

/* hw/beat_skid.sv */
`timescale 1ns/100ps
// Two-entry register slice for one valid/ready beat stream
// Main register drives the output, skid register absorbs the beat
// that arrives while the output is stalled
module beat_skid #(
   parameter type payload_t = logic
) (
   input logic    clk,
   input logic    sync_rst_n,
   beat_if.sink   up,
   beat_if.source dn
);

   logic     main_valid;
   logic     skid_valid;
   payload_t main_q;
   payload_t skid_q;
   logic     up_fire;
   logic     main_load;

   assign up_fire   = up.valid && up.ready;
   // Main register is free when empty or drained on this edge
   assign main_load = !main_valid || dn.ready;

   // Ready comes straight from a flop, so no path from dn.ready
   assign up.ready   = !skid_valid;
   assign dn.valid   = main_valid;
   assign dn.payload = main_q;

   // ------------------------------
   // Occupancy
   // ------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (main_load)
      begin
         // Skid entry moves up first, otherwise a new beat lands in main
         main_valid <= skid_valid || up_fire;
         skid_valid <= 1'b0;
      end
      else if (up_fire)
      begin
         skid_valid <= 1'b1;
      end
   end

   // ------------------------------
   // Payload registers
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (main_load)
      begin
         if (skid_valid)
         begin
            main_q <= skid_q;
         end
         else if (up_fire)
         begin
            main_q <= up.payload;
         end
      end
      if (!main_load && up_fire)
      begin
         skid_q <= up.payload;
      end
   end

   // Stalled output beat stays put until taken
   dn_hold_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      dn.valid && !dn.ready |=> dn.valid && $stable(dn.payload)
   );

endmodule

/* hw/cl_rdata_mult.sv */
`timescale 1ns/100ps
// Read-data product path top level
// Input slice, lane multiplier pipeline, output slice, control/status
module cl_rdata_mult #(
   parameter logic [31:0] VERSION   = rdata_mult_pkg::DEF_VERSION,
   parameter logic [31:0] ID0_VALUE = rdata_mult_pkg::DEF_ID0,
   parameter logic [31:0] ID1_VALUE = rdata_mult_pkg::DEF_ID1
) (
   input  logic                              clk,
   input  logic                              sync_rst_n,

   // Incoming read beats
   input  logic                              rd_in_valid,
   output logic                              rd_in_ready,
   input  logic [rdata_mult_pkg::BEAT_W-1:0] rd_in_data,
   input  logic [rdata_mult_pkg::ID_W-1:0]   rd_in_id,
   input  logic                              rd_in_last,

   // Product beats
   output logic                              rd_out_valid,
   input  logic                              rd_out_ready,
   output logic [rdata_mult_pkg::BEAT_W-1:0] rd_out_data,
   output logic [rdata_mult_pkg::ID_W-1:0]   rd_out_id,
   output logic                              rd_out_last,

   // Control and status
   input  logic [31:0]                       ctl0,
   output logic [31:0]                       status0,
   output logic [31:0]                       status1,
   output logic [31:0]                       id0,
   output logic [31:0]                       id1,
   input  logic                              flr_assert,
   output logic                              flr_done
);

   import rdata_mult_pkg::*;

   beat_if #(.payload_t(operand_beat_t)) in_beat ();
   beat_if #(.payload_t(operand_beat_t)) op_beat ();
   beat_if #(.payload_t(product_beat_t)) prod_beat ();
   beat_if #(.payload_t(product_beat_t)) out_beat ();

   // ------------------------------
   // Port mapping
   // ------------------------------
   // Lane i sits in data bits [64i+63:64i], upper half is hi
   assign in_beat.valid        = rd_in_valid;
   assign in_beat.payload.pair = rd_in_data;
   assign in_beat.payload.id   = rd_in_id;
   assign in_beat.payload.last = rd_in_last;
   assign rd_in_ready          = in_beat.ready;

   assign rd_out_valid   = out_beat.valid;
   assign rd_out_data    = out_beat.payload.prod;
   assign rd_out_id      = out_beat.payload.id;
   assign rd_out_last    = out_beat.payload.last;
   assign out_beat.ready = rd_out_ready;

   // ------------------------------
   // Datapath
   // ------------------------------
   beat_skid #(
      .payload_t (operand_beat_t)
   ) i_in_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .up         (in_beat),
      .dn         (op_beat)
   );

   lane_mult_pipe i_mult (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ops        (op_beat),
      .prods      (prod_beat)
   );

   beat_skid #(
      .payload_t (product_beat_t)
   ) i_out_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .up         (prod_beat),
      .dn         (out_beat)
   );

   // Status block watches delivered beats on the output stream
   ctl_status #(
      .VERSION   (VERSION),
      .ID0_VALUE (ID0_VALUE),
      .ID1_VALUE (ID1_VALUE)
   ) i_ctl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .mon        (out_beat),
      .flr_assert (flr_assert),
      .status0    (status0),
      .status1    (status1),
      .id0        (id0),
      .id1        (id1),
      .flr_done   (flr_done)
   );

endmodule

/* hw/ctl_status.sv */
`timescale 1ns/100ps
// Control register, delivered beat counter and product capture
// Status, version and ID words with debug lane readback
// FLR acknowledge
module ctl_status #(
   parameter logic [31:0] VERSION   = rdata_mult_pkg::DEF_VERSION,
   parameter logic [31:0] ID0_VALUE = rdata_mult_pkg::DEF_ID0,
   parameter logic [31:0] ID1_VALUE = rdata_mult_pkg::DEF_ID1
) (
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic [31:0] ctl0,
   beat_if.monitor     mon,
   input  logic        flr_assert,
   output logic [31:0] status0,
   output logic [31:0] status1,
   output logic [31:0] id0,
   output logic [31:0] id1,
   output logic        flr_done
);

   import rdata_mult_pkg::*;

   logic [31:0]                     ctl_q;
   logic                            dbg_en;
   logic [LANE_SEL_W-1:0]           lane_sel;
   logic                            mon_fire;
   logic [15:0]                     beat_cnt;
   logic [LANES-1:0][PRODUCT_W-1:0] cap_prod;
   logic [PRODUCT_W-1:0]            sel_prod;
   logic                            flr_q;

   assign dbg_en   = ctl_q[CTL_DBG_EN_BIT];
   assign lane_sel = ctl_q[CTL_LANE_SEL_LSB +: LANE_SEL_W];
   assign mon_fire = mon.valid && mon.ready;
   assign sel_prod = cap_prod[lane_sel];

   assign status0 = {STATUS_TAG, beat_cnt};
   assign status1 = VERSION;

   // ------------------------------
   // Control word and beat tracking
   // ------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q    <= '0;
         beat_cnt <= '0;
         cap_prod <= '0;
      end
      else
      begin
         ctl_q <= ctl0;
         if (mon_fire)
         begin
            // Counter wraps at 2^16
            beat_cnt <= beat_cnt + 16'd1;
            cap_prod <= mon.payload.prod;
         end
      end
   end

   // ID words, selected lane product when debug is on
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= ID0_VALUE;
         id1 <= ID1_VALUE;
      end
      else
      begin
         id0 <= dbg_en ? sel_prod[31:0] : ID0_VALUE;
         id1 <= dbg_en ? sel_prod[63:32] : ID1_VALUE;
      end
   end

   // ------------------------------
   // FLR acknowledge
   // ------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end
   end

   // Acknowledge is a single-cycle pulse
   flr_pulse_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   );

endmodule

/* hw/lane_mult_pipe.sv */
`timescale 1ns/100ps
// Stallable lane multiplier pipeline, hi * lo unsigned per 64-bit lane
// Operand capture, 48-bit partial products, summed 64-bit products
// Each stage holds one beat and advances when empty or drained
module lane_mult_pipe (
   input logic    clk,
   input logic    sync_rst_n,
   beat_if.sink   ops,
   beat_if.source prods
);

   import rdata_mult_pkg::*;

   localparam int HALF_W = OPERAND_W / 2;
   localparam int PP_W   = OPERAND_W + HALF_W;

   // Stage 1, operands as received
   logic                            s1_valid;
   operand_beat_t                   s1_q;
   // Stage 2, hi times each 16-bit half of lo
   logic                            s2_valid;
   logic [LANES-1:0][PP_W-1:0]      s2_pp_lo;
   logic [LANES-1:0][PP_W-1:0]      s2_pp_hi;
   logic [ID_W-1:0]                 s2_id;
   logic                            s2_last;
   // Stage 3, finished products
   logic                            s3_valid;
   product_beat_t                   s3_q;

   logic                            s1_adv;
   logic                            s2_adv;
   logic                            s3_adv;
   logic [LANES-1:0][PP_W-1:0]      pp_lo;
   logic [LANES-1:0][PP_W-1:0]      pp_hi;
   logic [LANES-1:0][PRODUCT_W-1:0] prod;

   // ------------------------------
   // Stall chain
   // ------------------------------
   assign s3_adv    = !s3_valid || prods.ready;
   assign s2_adv    = !s2_valid || s3_adv;
   assign s1_adv    = !s1_valid || s2_adv;
   assign ops.ready = s1_adv;

   assign prods.valid   = s3_valid;
   assign prods.payload = s3_q;

   // Split multiply, the shifted partial is weighted by 2^16
   always_comb
   begin
      for (int i = 0; i < LANES; i++)
      begin
         pp_lo[i] = s1_q.pair[i].hi * s1_q.pair[i].lo[HALF_W-1:0];
         pp_hi[i] = s1_q.pair[i].hi * s1_q.pair[i].lo[OPERAND_W-1:HALF_W];
         prod[i]  = PRODUCT_W'(s2_pp_lo[i]) + (PRODUCT_W'(s2_pp_hi[i]) << HALF_W);
      end
   end

   // ------------------------------
   // Stage valid bits
   // ------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         s3_valid <= 1'b0;
      end
      else
      begin
         if (s1_adv)
         begin
            s1_valid <= ops.valid;
         end
         if (s2_adv)
         begin
            s2_valid <= s1_valid;
         end
         if (s3_adv)
         begin
            s3_valid <= s2_valid;
         end
      end
   end

   // Stage data, loaded only when a beat moves in
   always_ff @(posedge clk)
   begin
      if (s1_adv && ops.valid)
      begin
         s1_q <= ops.payload;
      end
      if (s2_adv && s1_valid)
      begin
         s2_pp_lo <= pp_lo;
         s2_pp_hi <= pp_hi;
         s2_id    <= s1_q.id;
         s2_last  <= s1_q.last;
      end
      if (s3_adv && s2_valid)
      begin
         s3_q.prod <= prod;
         s3_q.id   <= s2_id;
         s3_q.last <= s2_last;
      end
   end

   // Product beat waiting on the output slice is not overwritten
   prod_hold_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      s3_valid && !prods.ready |=> s3_valid && $stable(s3_q)
   );

endmodule

/* hw/rdata_mult_pkg.sv */
// Shared widths and beat payload types for the read-data product path
// Control word bit positions, status tag and default ID/version words
package rdata_mult_pkg;

   // ------------------------------
   // Datapath widths
   // ------------------------------
   localparam int LANES     = 8;
   localparam int OPERAND_W = 32;
   localparam int PRODUCT_W = 2 * OPERAND_W;
   localparam int BEAT_W    = LANES * PRODUCT_W;
   localparam int ID_W      = 6;

   // One 64-bit lane of an input beat, upper half first
   typedef struct packed {
      logic [OPERAND_W-1:0] hi;
      logic [OPERAND_W-1:0] lo;
   } operand_pair_t;

   // Input beat, lane 0 in the low 64 bits of the data
   typedef struct packed {
      operand_pair_t [LANES-1:0] pair;
      logic [ID_W-1:0]           id;
      logic                      last;
   } operand_beat_t;

   // Output beat, product of lane i in output lane i
   typedef struct packed {
      logic [LANES-1:0][PRODUCT_W-1:0] prod;
      logic [ID_W-1:0]                 id;
      logic                            last;
   } product_beat_t;

   // ------------------------------
   // Control and status words
   // ------------------------------
   localparam int CTL_DBG_EN_BIT   = 31;
   localparam int CTL_LANE_SEL_LSB = 28;
   localparam int LANE_SEL_W       = 3;

   localparam logic [15:0] STATUS_TAG  = 16'ha111;
   localparam logic [31:0] DEF_VERSION = 32'hee_ee_ee_00;
   // PCI vendor/device and subsystem IDs
   localparam logic [31:0] DEF_ID0     = 32'hf001_1d0f;
   localparam logic [31:0] DEF_ID1     = 32'h1d51_fedc;

endpackage

/* list.f */
hw/rdata_mult_pkg.sv
hw/beat_if.sv
hw/beat_skid.sv
hw/lane_mult_pipe.sv
hw/ctl_status.sv
hw/cl_rdata_mult.sv
dv/tb_cl_rdata_mult.sv
